// File: design/ex_pkg.sv
package ex_pkg;

    localparam int xlen         = 32;
    localparam int rob_size     = 32;
    localparam int tag_w        = $clog2(rob_size);
    localparam int num_ways     = 3;   // issue lanes, also alus and mults
    localparam int mult_stages  = 4;
    localparam int num_slots    = 2 * num_ways;
    localparam int mult_chunk_w = 2 * xlen / mult_stages; // multiplier bits folded in per stage

    typedef logic [xlen-1:0]  data_t;
    typedef logic [tag_w-1:0] tag_t;

    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_kind_e;

    // integer and branch functions
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_sll  = 4'h5,
        alu_srl  = 4'h6,
        alu_sra  = 4'h7,
        alu_slt  = 4'h8,
        alu_sltu = 4'h9,
        alu_beq  = 4'ha,
        alu_bne  = 4'hb,
        alu_blt  = 4'hc,
        alu_bge  = 4'hd
    } alu_op_e;

    typedef enum logic [3:0] {
        mul_mul    = 4'h0,
        mul_mulh   = 4'h1,
        mul_mulhsu = 4'h2,
        mul_mulhu  = 4'h3
    } mul_op_e;

    // same four bits, meaning depends on the unit kind
    typedef union packed {
        alu_op_e alu;
        mul_op_e mul;
    } fu_op_u;

endpackage

// File: design/fu_issue_if.sv
`timescale 1ns/10ps

interface fu_issue_if import ex_pkg::*; ();

    logic   valid;
    logic   ready;   // unit can take an op this cycle
    fu_op_u op;
    tag_t   tag;
    data_t  opa;
    data_t  opb;
    data_t  npc;
    logic   halt;

    modport router (
        output valid, op, tag, opa, opb, npc, halt,
        input  ready
    );

    modport unit (
        input  valid, op, tag, opa, opb, npc, halt,
        output ready
    );

endinterface

// File: design/fu_result_if.sv
`timescale 1ns/10ps

interface fu_result_if import ex_pkg::*; ();

    logic  valid;
    logic  ready;         // slot empty or draining
    tag_t  tag;
    data_t value;
    data_t npc;
    logic  halt;
    logic  branch_taken;

    modport unit (
        output valid, tag, value, npc, halt, branch_taken,
        input  ready
    );

    modport buffer (
        input  valid, tag, value, npc, halt, branch_taken,
        output ready
    );

endinterface

// File: design/issue_router.sv
`timescale 1ns/10ps

module issue_router import ex_pkg::*; (
    input  logic [num_ways-1:0]     issue_valid,
    input  fu_kind_e [num_ways-1:0] issue_kind,
    input  fu_op_u [num_ways-1:0]   issue_op,
    input  tag_t [num_ways-1:0]     issue_tag,
    input  data_t [num_ways-1:0]    issue_opa,
    input  data_t [num_ways-1:0]    issue_opb,
    input  data_t [num_ways-1:0]    issue_npc,
    input  logic [num_ways-1:0]     issue_halt,
    output logic [num_ways-1:0]     alu_free,
    output logic [num_ways-1:0]     mult_free,
    fu_issue_if.router              alu_port [num_ways],
    fu_issue_if.router              mult_port [num_ways]
);

    // lane i only ever feeds alu i or mult i
    for (genvar i = 0; i < num_ways; i++) begin : g_lane
        assign alu_port[i].valid  = issue_valid[i] && (issue_kind[i] == fu_alu);
        assign mult_port[i].valid = issue_valid[i] && (issue_kind[i] == fu_mult);

        // payload goes to both, valid picks the taker
        assign alu_port[i].op   = issue_op[i];
        assign alu_port[i].tag  = issue_tag[i];
        assign alu_port[i].opa  = issue_opa[i];
        assign alu_port[i].opb  = issue_opb[i];
        assign alu_port[i].npc  = issue_npc[i];
        assign alu_port[i].halt = issue_halt[i];

        assign mult_port[i].op   = issue_op[i];
        assign mult_port[i].tag  = issue_tag[i];
        assign mult_port[i].opa  = issue_opa[i];
        assign mult_port[i].opb  = issue_opb[i];
        assign mult_port[i].npc  = issue_npc[i];
        assign mult_port[i].halt = issue_halt[i];

        // free flags back to the reservation station
        assign alu_free[i]  = alu_port[i].ready;
        assign mult_free[i] = mult_port[i].ready;
    end

endmodule

// File: design/int_alu.sv
`timescale 1ns/10ps

module int_alu import ex_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        clear,
    fu_issue_if.unit    issue,
    fu_result_if.unit   result
);

    data_t alu_value;
    logic  alu_taken;
    logic  accept;

    // free unless a result sits unclaimed
    assign issue.ready = !result.valid || result.ready;
    assign accept      = issue.valid && issue.ready;

    always_comb begin
        alu_value = '0;
        alu_taken = 1'b0;
        case (issue.op.alu)
            alu_add:  alu_value = issue.opa + issue.opb;
            alu_sub:  alu_value = issue.opa - issue.opb;
            alu_and:  alu_value = issue.opa & issue.opb;
            alu_or:   alu_value = issue.opa | issue.opb;
            alu_xor:  alu_value = issue.opa ^ issue.opb;
            alu_sll:  alu_value = issue.opa << issue.opb[4:0];
            alu_srl:  alu_value = issue.opa >> issue.opb[4:0];
            alu_sra:  alu_value = $signed(issue.opa) >>> issue.opb[4:0];
            alu_slt:  alu_value = {{(xlen-1){1'b0}}, ($signed(issue.opa) < $signed(issue.opb))};
            alu_sltu: alu_value = {{(xlen-1){1'b0}}, (issue.opa < issue.opb)};
            // branches only produce the taken flag
            alu_beq:  alu_taken = (issue.opa == issue.opb);
            alu_bne:  alu_taken = (issue.opa != issue.opb);
            alu_blt:  alu_taken = ($signed(issue.opa) < $signed(issue.opb));
            alu_bge:  alu_taken = ($signed(issue.opa) >= $signed(issue.opb));
            default:  alu_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            result.valid <= 1'b0;
        end else if (accept) begin
            result.valid <= 1'b1;
        end else if (result.ready) begin
            result.valid <= 1'b0;   // taken by the buffer
        end
    end

    // output register, held while back-pressured
    always_ff @(posedge clock) begin
        if (accept) begin
            result.value        <= alu_value;
            result.branch_taken <= alu_taken;
            result.tag          <= issue.tag;
            result.npc          <= issue.npc;
            result.halt         <= issue.halt;
        end
    end

endmodule

// File: design/pipelined_mult.sv
`timescale 1ns/10ps

module pipelined_mult import ex_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        clear,
    fu_issue_if.unit    issue,
    fu_result_if.unit   result
);

    logic [2*xlen-1:0]    in_a, in_b;
    logic                 sign_a, sign_b;
    logic                 keep_hi;
    logic                 advance;
    logic [mult_stages-1:0] s_valid;
    logic [2*xlen-1:0]    s_a [mult_stages-1];   // operands, not needed after last fold
    logic [2*xlen-1:0]    s_b [mult_stages-1];
    logic [2*xlen-1:0]    s_acc [mult_stages];
    logic                 s_hi [mult_stages];
    tag_t                 s_tag [mult_stages];
    data_t                s_npc [mult_stages];
    logic                 s_halt [mult_stages];

    // one chunk of b times a, shifted into place
    function automatic logic [2*xlen-1:0] partial(input logic [2*xlen-1:0] a,
                                                  input logic [2*xlen-1:0] b,
                                                  input int k);
        logic [mult_chunk_w-1:0] chunk;
        chunk = b[k*mult_chunk_w +: mult_chunk_w];
        return (a * {{(2*xlen-mult_chunk_w){1'b0}}, chunk}) << (k * mult_chunk_w);
    endfunction

    // signedness per rv32m op
    always_comb begin
        sign_a  = (issue.op.mul == mul_mulh) || (issue.op.mul == mul_mulhsu);
        sign_b  = (issue.op.mul == mul_mulh);
        keep_hi = (issue.op.mul != mul_mul);
        in_a    = {{xlen{sign_a & issue.opa[xlen-1]}}, issue.opa};
        in_b    = {{xlen{sign_b & issue.opb[xlen-1]}}, issue.opb};
    end

    // whole pipe stalls on an untaken result
    assign advance     = !s_valid[mult_stages-1] || result.ready;
    assign issue.ready = advance;

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            s_valid <= '0;
        end else if (advance) begin
            s_valid <= {s_valid[mult_stages-2:0], issue.valid};
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            s_a[0]    <= in_a;
            s_b[0]    <= in_b;
            s_acc[0]  <= partial(in_a, in_b, 0);
            s_hi[0]   <= keep_hi;
            s_tag[0]  <= issue.tag;
            s_npc[0]  <= issue.npc;
            s_halt[0] <= issue.halt;
            for (int k = 1; k < mult_stages; k++) begin
                s_acc[k]  <= s_acc[k-1] + partial(s_a[k-1], s_b[k-1], k);
                s_hi[k]   <= s_hi[k-1];
                s_tag[k]  <= s_tag[k-1];
                s_npc[k]  <= s_npc[k-1];
                s_halt[k] <= s_halt[k-1];
            end
            for (int k = 1; k < mult_stages - 1; k++) begin
                s_a[k] <= s_a[k-1];
                s_b[k] <= s_b[k-1];
            end
        end
    end

    assign result.valid        = s_valid[mult_stages-1];
    assign result.tag          = s_tag[mult_stages-1];
    assign result.npc          = s_npc[mult_stages-1];
    assign result.halt         = s_halt[mult_stages-1];
    assign result.branch_taken = 1'b0;
    assign result.value        = s_hi[mult_stages-1] ? s_acc[mult_stages-1][2*xlen-1:xlen]
                                                     : s_acc[mult_stages-1][xlen-1:0];

endmodule

// File: design/complete_buffer.sv
`timescale 1ns/10ps

module complete_buffer import ex_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 clear,
    fu_result_if.buffer          mult_res [num_ways],
    fu_result_if.buffer          alu_res [num_ways],
    output logic [num_ways-1:0]  cdb_valid,
    output tag_t [num_ways-1:0]  cdb_tag,
    output data_t [num_ways-1:0] cdb_value,
    output data_t [num_ways-1:0] cdb_npc,
    output logic [num_ways-1:0]  cdb_halt,
    output logic [num_ways-1:0]  cdb_branch_taken
);

    // slot order: mults first, then alus
    logic [num_slots-1:0]  in_valid, in_halt, in_bt;
    tag_t [num_slots-1:0]  in_tag;
    data_t [num_slots-1:0] in_value, in_npc;
    logic [num_slots-1:0]  slot_v, slot_halt, slot_bt;
    tag_t [num_slots-1:0]  slot_tag;
    data_t [num_slots-1:0] slot_value, slot_npc;
    logic [num_slots-1:0]  grant;
    logic [num_slots-1:0]  rdy;
    logic [num_ways-1:0]   nxt_valid, nxt_halt, nxt_bt;
    tag_t [num_ways-1:0]   nxt_tag;
    data_t [num_ways-1:0]  nxt_value, nxt_npc;

    for (genvar i = 0; i < num_ways; i++) begin : g_unit
        assign in_valid[i]          = mult_res[i].valid;
        assign in_tag[i]            = mult_res[i].tag;
        assign in_value[i]          = mult_res[i].value;
        assign in_npc[i]            = mult_res[i].npc;
        assign in_halt[i]           = mult_res[i].halt;
        assign in_bt[i]             = mult_res[i].branch_taken;
        assign mult_res[i].ready    = rdy[i];
        assign in_valid[num_ways+i] = alu_res[i].valid;
        assign in_tag[num_ways+i]   = alu_res[i].tag;
        assign in_value[num_ways+i] = alu_res[i].value;
        assign in_npc[num_ways+i]   = alu_res[i].npc;
        assign in_halt[num_ways+i]  = alu_res[i].halt;
        assign in_bt[num_ways+i]    = alu_res[i].branch_taken;
        assign alu_res[i].ready     = rdy[num_ways+i];
    end

    // a full slot takes new data only while it drains
    assign rdy = ~slot_v | grant;

    // first three occupied slots, held entry before a fresh one
    always_comb begin
        int lane;
        lane      = 0;
        grant     = '0;
        nxt_valid = '0;
        nxt_tag   = '0;
        nxt_value = '0;
        nxt_npc   = '0;
        nxt_halt  = '0;
        nxt_bt    = '0;
        for (int s = 0; s < num_slots; s++) begin
            if ((slot_v[s] || in_valid[s]) && lane < num_ways) begin
                grant[s]        = 1'b1;
                nxt_valid[lane] = 1'b1;
                nxt_tag[lane]   = slot_v[s] ? slot_tag[s]   : in_tag[s];
                nxt_value[lane] = slot_v[s] ? slot_value[s] : in_value[s];
                nxt_npc[lane]   = slot_v[s] ? slot_npc[s]   : in_npc[s];
                nxt_halt[lane]  = slot_v[s] ? slot_halt[s]  : in_halt[s];
                nxt_bt[lane]    = slot_v[s] ? slot_bt[s]    : in_bt[s];
                lane            = lane + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            slot_v <= '0;
        end else begin
            for (int s = 0; s < num_slots; s++) begin
                // fresh result bypassed to the bus leaves the slot empty
                if (rdy[s]) slot_v[s] <= in_valid[s] && (slot_v[s] || !grant[s]);
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < num_slots; s++) begin
            if (rdy[s] && in_valid[s]) begin
                slot_tag[s]   <= in_tag[s];
                slot_value[s] <= in_value[s];
                slot_npc[s]   <= in_npc[s];
                slot_halt[s]  <= in_halt[s];
                slot_bt[s]    <= in_bt[s];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            cdb_valid        <= '0;
            cdb_tag          <= '0;
            cdb_value        <= '0;
            cdb_npc          <= '0;
            cdb_halt         <= '0;
            cdb_branch_taken <= '0;
        end else begin
            cdb_valid        <= nxt_valid;
            cdb_tag          <= nxt_tag;
            cdb_value        <= nxt_value;
            cdb_npc          <= nxt_npc;
            cdb_halt         <= nxt_halt;
            cdb_branch_taken <= nxt_bt;
        end
    end

endmodule

// File: design/ex_stage.sv
`timescale 1ns/10ps

module ex_stage import ex_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    clear,      // squash everything in flight
    input  logic [num_ways-1:0]     issue_valid,
    input  fu_kind_e [num_ways-1:0] issue_kind,
    input  fu_op_u [num_ways-1:0]   issue_op,
    input  tag_t [num_ways-1:0]     issue_tag,
    input  data_t [num_ways-1:0]    issue_opa,
    input  data_t [num_ways-1:0]    issue_opb,
    input  data_t [num_ways-1:0]    issue_npc,
    input  logic [num_ways-1:0]     issue_halt,
    output logic [num_ways-1:0]     alu_free,
    output logic [num_ways-1:0]     mult_free,
    output logic [num_ways-1:0]     cdb_valid,
    output tag_t [num_ways-1:0]     cdb_tag,
    output data_t [num_ways-1:0]    cdb_value,
    output data_t [num_ways-1:0]    cdb_npc,
    output logic [num_ways-1:0]     cdb_halt,
    output logic [num_ways-1:0]     cdb_branch_taken
);

    fu_issue_if  alu_issue [num_ways] ();
    fu_issue_if  mult_issue [num_ways] ();
    fu_result_if alu_result [num_ways] ();
    fu_result_if mult_result [num_ways] ();

    issue_router router0 (
        .issue_valid (issue_valid),
        .issue_kind  (issue_kind),
        .issue_op    (issue_op),
        .issue_tag   (issue_tag),
        .issue_opa   (issue_opa),
        .issue_opb   (issue_opb),
        .issue_npc   (issue_npc),
        .issue_halt  (issue_halt),
        .alu_free    (alu_free),
        .mult_free   (mult_free),
        .alu_port    (alu_issue),
        .mult_port   (mult_issue)
    );

    for (genvar g = 0; g < num_ways; g++) begin : g_fu
        int_alu alu0 (
            .clock  (clock),
            .reset  (reset),
            .clear  (clear),
            .issue  (alu_issue[g]),
            .result (alu_result[g])
        );

        pipelined_mult mult0 (
            .clock  (clock),
            .reset  (reset),
            .clear  (clear),
            .issue  (mult_issue[g]),
            .result (mult_result[g])
        );
    end

    complete_buffer cbuf0 (
        .clock            (clock),
        .reset            (reset),
        .clear            (clear),
        .mult_res         (mult_result),
        .alu_res          (alu_result),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .cdb_npc          (cdb_npc),
        .cdb_halt         (cdb_halt),
        .cdb_branch_taken (cdb_branch_taken)
    );

endmodule

// File: sim/ex_stage_chk.sv
`timescale 1ns/10ps

module ex_stage_chk import ex_pkg::*; (
    input logic                clock,
    input logic                reset,
    input logic [num_ways-1:0] issue_valid,
    input logic [num_ways-1:0] issue_kind,   // set bit selects the multiplier
    input logic [num_ways-1:0] alu_free,
    input logic [num_ways-1:0] mult_free,
    input logic [num_ways-1:0] cdb_valid
);

    int reset_fails = 0;
    int order_fails = 0;
    int issue_fails = 0;
    int fail_count;

    assign fail_count = reset_fails + order_fails + issue_fails;

    // bus quiet one edge after reset
    a_reset_idle: assert property (@(posedge clock) reset |=> cdb_valid == '0)
        else begin
            reset_fails++;
            $error("cdb_valid high after a reset edge");
        end

    // lanes fill from lane 0 without gaps
    a_lane_order: assert property (@(posedge clock) disable iff (reset)
        (cdb_valid & (cdb_valid + 1'b1)) == '0)
        else begin
            order_fails++;
            $error("cdb_valid lanes not contiguous from lane 0");
        end

    a_issue_free: assert property (@(posedge clock) disable iff (reset)
        (issue_valid & ((~issue_kind & ~alu_free) | (issue_kind & ~mult_free))) == '0)
        else begin
            issue_fails++;
            $error("operation issued to a unit that is not free");
        end

endmodule

bind ex_stage ex_stage_chk chk0 (.*);

// File: sim/ex_stage_tb.sv
`timescale 1ns/10ps

module ex_stage_tb import ex_pkg::*; ();

    localparam int clk_period    = 20;
    localparam int drive_delay   = 2;
    localparam int reset_cycles  = 16;
    localparam int alu_latency   = 2;                // edges from drive to bus
    localparam int mult_latency  = mult_stages + 1;
    localparam int test_cycles   = reset_cycles + 1 + (num_ways * 10 + 12) * alu_latency
                                   + (mult_stages + mult_latency) + (mult_latency + 3)
                                   + (mult_stages + mult_latency + 3);
    localparam int margin_cycles = 50;

    logic                    clock;
    logic                    reset;
    logic                    clear;
    logic [num_ways-1:0]     issue_valid;
    fu_kind_e [num_ways-1:0] issue_kind;
    fu_op_u [num_ways-1:0]   issue_op;
    tag_t [num_ways-1:0]     issue_tag;
    data_t [num_ways-1:0]    issue_opa;
    data_t [num_ways-1:0]    issue_opb;
    data_t [num_ways-1:0]    issue_npc;
    logic [num_ways-1:0]     issue_halt;
    logic [num_ways-1:0]     alu_free;
    logic [num_ways-1:0]     mult_free;
    logic [num_ways-1:0]     cdb_valid;
    tag_t [num_ways-1:0]     cdb_tag;
    data_t [num_ways-1:0]    cdb_value;
    data_t [num_ways-1:0]    cdb_npc;
    logic [num_ways-1:0]     cdb_halt;
    logic [num_ways-1:0]     cdb_branch_taken;

    int errors;
    int checks;
    int seed;

    ex_stage dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("watchdog timeout after %0d cycles, run stopped", test_cycles + margin_cycles);
        $display("Test failed");
        $finish;
    end

    task automatic next_edge();
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic compare(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic idle_inputs();
        for (int i = 0; i < num_ways; i++) begin
            issue_valid[i] = 1'b0;
            issue_kind[i]  = fu_alu;
            issue_op[i]    = 4'h0;
            issue_tag[i]   = '0;
            issue_opa[i]   = '0;
            issue_opb[i]   = '0;
            issue_npc[i]   = '0;
            issue_halt[i]  = 1'b0;
        end
    endtask

    task automatic drive_lane(input int lane, input fu_kind_e kind, input logic [3:0] code,
                              input tag_t tag, input data_t opa, input data_t opb,
                              input data_t npc, input logic halt);
        issue_valid[lane] = 1'b1;
        issue_kind[lane]  = kind;
        issue_op[lane]    = code;
        issue_tag[lane]   = tag;
        issue_opa[lane]   = opa;
        issue_opb[lane]   = opb;
        issue_npc[lane]   = npc;
        issue_halt[lane]  = halt;
    endtask

    task automatic check_lane(input int lane, input tag_t tag, input data_t value,
                              input data_t npc, input logic halt, input logic taken);
        compare($sformatf("cdb_valid[%0d]", lane), 32'(cdb_valid[lane]), 32'd1);
        compare($sformatf("cdb_tag[%0d]", lane), 32'(cdb_tag[lane]), 32'(tag));
        compare($sformatf("cdb_value[%0d]", lane), cdb_value[lane], value);
        compare($sformatf("cdb_npc[%0d]", lane), cdb_npc[lane], npc);
        compare($sformatf("cdb_halt[%0d]", lane), 32'(cdb_halt[lane]), 32'(halt));
        compare($sformatf("cdb_branch_taken[%0d]", lane), 32'(cdb_branch_taken[lane]),
                32'(taken));
    endtask

    // rv32i reference value where branches give zero
    function automatic data_t alu_expect(input alu_op_e op, input data_t a, input data_t b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        int sh;
        sa = a;
        sb = b;
        sh = int'(b[4:0]);   // low five bits only
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return data_t'(sa >>> sh);
            alu_slt:  return (sa < sb) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_expect(input alu_op_e op, input data_t a, input data_t b);
        logic lt;
        // signed less-than from the sign bits
        lt = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b);
        case (op)
            alu_beq: return a == b;
            alu_bne: return a != b;
            alu_blt: return lt;
            alu_bge: return !lt;
            default: return 1'b0;
        endcase
    endfunction

    function automatic data_t mul_expect(input mul_op_e op, input data_t a, input data_t b);
        logic               a_signed;
        logic               b_signed;
        logic [2*xlen-1:0]  ea;
        logic [2*xlen-1:0]  eb;
        logic [2*xlen-1:0]  prod;
        a_signed = (op == mul_mulh) || (op == mul_mulhsu);
        b_signed = (op == mul_mulh);
        ea       = {{xlen{a_signed & a[xlen-1]}}, a};
        eb       = {{xlen{b_signed & b[xlen-1]}}, b};
        prod     = ea * eb;   // 64 bits are enough for the high word
        return (op == mul_mul) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];
    endfunction

    task automatic run_alu(input int lane, input alu_op_e op, input tag_t tag,
                           input data_t a, input data_t b);
        data_t npc;
        logic  halt;
        npc  = $random(seed);
        halt = 1'($random(seed));
        drive_lane(lane, fu_alu, op, tag, a, b, npc, halt);
        next_edge();
        idle_inputs();
        next_edge();
        compare("cdb_valid", 32'(cdb_valid), 32'd1);   // alone so it lands on lane 0
        check_lane(0, tag, alu_expect(op, a, b), npc, halt, branch_expect(op, a, b));
    endtask

    task automatic test_reset();
        compare("cdb_valid", 32'(cdb_valid), 32'd0);
        compare("alu_free", 32'(alu_free), 32'({num_ways{1'b1}}));
        compare("mult_free", 32'(mult_free), 32'({num_ways{1'b1}}));
    endtask

    task automatic test_alu_ops();
        tag_t tag;
        tag = '0;
        for (int lane = 0; lane < num_ways; lane++) begin
            for (int code = int'(alu_add); code <= int'(alu_sltu); code++) begin
                run_alu(lane, alu_op_e'(4'(code)), tag, $random(seed), $random(seed));
                tag = tag + 1'b1;
            end
        end
    endtask

    task automatic test_branches();
        data_t a [3];
        data_t b [3];
        int    n;
        a[0] = $random(seed);
        b[0] = a[0];
        a[1] = 32'hffff_fff0;   // negative, smaller
        b[1] = 32'h0000_0010;
        a[2] = 32'h0000_0010;
        b[2] = 32'hffff_fff0;
        n = 0;
        for (int code = int'(alu_beq); code <= int'(alu_bge); code++) begin
            for (int k = 0; k < 3; k++) begin
                run_alu(n % num_ways, alu_op_e'(4'(code)), tag_t'(n), a[k], b[k]);
                n++;
            end
        end
    endtask

    task automatic test_mult_pipeline();
        data_t   exp_value [mult_stages];
        data_t   exp_npc [mult_stages];
        data_t   a;
        data_t   b;
        mul_op_e op;
        for (int k = 0; k < mult_stages; k++) begin
            op           = mul_op_e'(4'(k % 4));
            a            = $random(seed);
            b            = $random(seed);
            exp_npc[k]   = $random(seed);
            exp_value[k] = mul_expect(op, a, b);
            drive_lane(2, fu_mult, op, tag_t'(8 + k), a, b, exp_npc[k], 1'(k));
            next_edge();
        end
        idle_inputs();
        repeat (mult_latency - mult_stages) next_edge();
        for (int k = 0; k < mult_stages; k++) begin
            compare("cdb_valid", 32'(cdb_valid), 32'd1);
            check_lane(0, tag_t'(8 + k), exp_value[k], exp_npc[k], 1'(k), 1'b0);
            next_edge();
        end
        compare("cdb_valid", 32'(cdb_valid), 32'd0);
    endtask

    // mults and alus finish on the same edge
    task automatic test_contention();
        data_t mult_val [num_ways];
        data_t alu_val [num_ways];
        data_t a;
        data_t b;
        for (int i = 0; i < num_ways; i++) begin
            a           = $random(seed);
            b           = $random(seed);
            mult_val[i] = mul_expect(mul_mulhu, a, b);
            drive_lane(i, fu_mult, mul_mulhu, tag_t'(16 + i), a, b, data_t'(i), 1'b0);
        end
        next_edge();
        idle_inputs();
        repeat (mult_stages - 2) next_edge();
        for (int i = 0; i < num_ways; i++) begin
            a          = $random(seed);
            b          = $random(seed);
            alu_val[i] = alu_expect(alu_xor, a, b);
            drive_lane(i, fu_alu, alu_xor, tag_t'(24 + i), a, b, data_t'(8 + i), 1'b1);
        end
        next_edge();
        idle_inputs();
        next_edge();
        for (int i = 0; i < num_ways; i++) check_lane(i, tag_t'(16 + i), mult_val[i],
                                                      data_t'(i), 1'b0, 1'b0);
        next_edge();
        for (int i = 0; i < num_ways; i++) check_lane(i, tag_t'(24 + i), alu_val[i],
                                                      data_t'(8 + i), 1'b1, 1'b0);
        next_edge();
        compare("cdb_valid", 32'(cdb_valid), 32'd0);
    endtask

    // mults fill the bus every cycle so the last alu backs up when clear hits
    task automatic test_clear();
        logic [num_ways-1:0] stalled_free;
        stalled_free             = '1;
        stalled_free[num_ways-1] = 1'b0;   // last alu holds a result with no slot
        for (int c = 0; c <= mult_stages; c++) begin
            for (int i = 0; i < num_ways; i++) begin
                if (i == num_ways - 1 && c >= mult_stages - 1) begin
                    drive_lane(i, fu_alu, alu_add, tag_t'(28 + i), $random(seed),
                               $random(seed), $random(seed), 1'b0);
                end else begin
                    drive_lane(i, fu_mult, mul_mul, tag_t'(28 + i), $random(seed),
                               $random(seed), $random(seed), 1'b0);
                end
            end
            next_edge();
        end
        idle_inputs();
        compare("alu_free", 32'(alu_free), 32'(stalled_free));
        clear = 1'b1;
        next_edge();
        clear = 1'b0;
        compare("alu_free", 32'(alu_free), 32'({num_ways{1'b1}}));
        compare("mult_free", 32'(mult_free), 32'({num_ways{1'b1}}));
        compare("cdb_valid", 32'(cdb_valid), 32'd0);
        // nothing issued since so any valid lane is a squashed tag
        repeat (mult_latency + 1) begin
            next_edge();
            compare("cdb_valid", 32'(cdb_valid), 32'd0);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        seed   = 32'h9e2cdcd6;
        reset  = 1'b1;
        clear  = 1'b0;
        idle_inputs();
        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        reset = 1'b0;
        next_edge();
        test_reset();
        test_alu_ops();
        test_branches();
        test_mult_pipeline();
        test_contention();
        test_clear();
        errors = errors + dut0.chk0.fail_count;   // bound assertion failures
        $display("checks %0d, errors %0d (assertion failures %0d)", checks, errors,
                 dut0.chk0.fail_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
design/ex_pkg.sv
design/fu_issue_if.sv
design/fu_result_if.sv
design/issue_router.sv
design/int_alu.sv
design/pipelined_mult.sv
design/complete_buffer.sv
design/ex_stage.sv
sim/ex_stage_chk.sv
sim/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module ex_stage_tb -f compile.f -o ex_stage_sim &&
{ ./obj_dir/ex_stage_sim +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "Test failed" sim.log &&
grep -q "Test completed successfully" sim.log &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
